// File: rtl/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] dataWord;
	typedef logic [4:0]  regAddr;
	typedef logic [1:0]  stageTime;
	typedef logic [1:0]  bypassSel;

	// Bypass source codes
	localparam bypassSel bypRf  = 2'd0;
	localparam bypassSel bypMem = 2'd1;
	localparam bypassSel bypWb  = 2'd2;

	// Time until used, counted from decode
	localparam stageTime useBranch    = 2'd0;
	localparam stageTime useAlu       = 2'd1;
	localparam stageTime useStoreData = 2'd2;

	// Time until new, counted from execute
	localparam stageTime newNone = 2'd0;
	localparam stageTime newAlu  = 2'd1;
	localparam stageTime newLoad = 2'd2;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOp;

	//////////////////////////////////////////////////////////////
	// Opcodes and R-type function codes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri   = 6'h0D;
	localparam logic [5:0] opLui   = 6'h0F;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2B;

	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSubu = 6'h23;
	localparam logic [5:0] functAnd  = 6'h24;
	localparam logic [5:0] functOr   = 6'h25;
	localparam logic [5:0] functSlt  = 6'h2A;

	localparam int imemDepth    = 64;
	localparam int dmemDepth    = 64;
	localparam int imemAddrBits = $clog2(imemDepth);
	localparam int dmemAddrBits = $clog2(dmemDepth);

endpackage

// File: rtl/fetchStage.sv
module fetchStage import cpuPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    progWe,
	input  dataWord progAddr,
	input  dataWord progData,
	input  logic    stall,
	input  logic    redirect,
	input  dataWord redirectPc,
	output dataWord instrId,
	output dataWord pcId
);

	dataWord pc;
	dataWord nextPc;
	dataWord imem [imemDepth];

	// Program load, byte addressed
	always_ff @(posedge clk) begin
		if (progWe) begin
			imem[progAddr[imemAddrBits+1:2]] <= progData;
		end
	end

	// Branch target from decode, else sequential
	assign nextPc = redirect ? redirectPc : pc + 32'd4;

	//////////////////////////////////////////////////////////////
	// PC and IF/ID register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= '0;
			instrId <= '0;
			pcId    <= '0;
		end else if (!stall) begin
			pc      <= nextPc;
			instrId <= imem[pc[imemAddrBits+1:2]];
			pcId    <= pc;
		end
	end

	progLoadInReset: assert property (@(posedge clk) progWe |-> rst)
		else $error("program load strobe outside reset");

endmodule

// File: rtl/decodeStage.sv
module decodeStage import cpuPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     stall,
	input  dataWord  instrId,
	input  dataWord  pcId,
	input  bypassSel rsSelId,
	input  bypassSel rtSelId,
	input  dataWord  memFwdData,
	input  regAddr   wbReg,
	input  dataWord  wbData,
	input  logic     wbEn,
	output logic     redirect,
	output dataWord  redirectPc,
	output regAddr   rsId,
	output regAddr   rtId,
	output stageTime rsUseId,
	output stageTime rtUseId,
	output regAddr   rsEx,
	output regAddr   rtEx,
	output regAddr   dstEx,
	output stageTime rsUseEx,
	output stageTime rtUseEx,
	output stageTime dstNewEx,
	output aluOp     opEx,
	output logic     useImmEx,
	output logic     loadEx,
	output logic     storeEx,
	output dataWord  rsValEx,
	output dataWord  rtValEx,
	output dataWord  immEx,
	output dataWord  pcEx
);

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [15:0] imm16;
	regAddr      dst;
	stageTime    dstNew;
	aluOp        op;
	logic        rType, useImm, isLoad, isStore, isBeq, isJ;
	dataWord     immExt, rfRs, rfRt, rsVal, rtVal, pcPlus4;
	dataWord     regFile [32];

	assign opcode = instrId[31:26];
	assign funct  = instrId[5:0];
	assign imm16  = instrId[15:0];

	always_comb begin
		rsId    = '0;
		rtId    = '0;
		rsUseId = useBranch;
		rtUseId = useBranch;
		dst     = '0;
		dstNew  = newNone;
		op      = aluAdd;
		rType   = 1'b0;
		useImm  = 1'b0;
		isLoad  = 1'b0;
		isStore = 1'b0;
		isBeq   = 1'b0;
		isJ     = 1'b0;
		immExt  = {{16{imm16[15]}}, imm16};
		case (opcode)
			opRType: begin
				rType = 1'b1;
				case (funct)
					functAddu: op = aluAdd;
					functSubu: op = aluSub;
					functAnd:  op = aluAnd;
					functOr:   op = aluOr;
					functSlt:  op = aluSlt;
					default:   rType = 1'b0;
				endcase
				if (rType) begin
					rsId    = instrId[25:21];
					rtId    = instrId[20:16];
					rsUseId = useAlu;
					rtUseId = useAlu;
					dst     = instrId[15:11];
					dstNew  = newAlu;
				end
			end
			opAddiu, opOri, opLw: begin
				rsId    = instrId[25:21];
				rsUseId = useAlu;
				dst     = instrId[20:16];
				useImm  = 1'b1;
				isLoad  = (opcode == opLw);
				dstNew  = isLoad ? newLoad : newAlu;
				if (opcode == opOri) begin
					op     = aluOr;
					immExt = {16'h0, imm16};
				end
			end
			opLui: begin
				dst    = instrId[20:16];
				dstNew = newAlu;
				op     = aluLui;
				useImm = 1'b1;
			end
			opSw: begin
				rsId    = instrId[25:21];
				rtId    = instrId[20:16];
				rsUseId = useAlu;
				rtUseId = useStoreData;
				useImm  = 1'b1;
				isStore = 1'b1;
			end
			opBeq: begin
				rsId  = instrId[25:21];
				rtId  = instrId[20:16];
				isBeq = 1'b1;
			end
			opJ: isJ = 1'b1;
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////
	// Register file with write-through from WB
	always_ff @(posedge clk) begin
		if (wbEn) begin
			regFile[wbReg] <= wbData;
		end
	end

	assign rfRs = (rsId == '0) ? '0 : (wbEn && wbReg == rsId) ? wbData : regFile[rsId];
	assign rfRt = (rtId == '0) ? '0 : (wbEn && wbReg == rtId) ? wbData : regFile[rtId];

	// Decode-side bypass
	assign rsVal = (rsSelId == bypMem) ? memFwdData : (rsSelId == bypWb) ? wbData : rfRs;
	assign rtVal = (rtSelId == bypMem) ? memFwdData : (rtSelId == bypWb) ? wbData : rfRt;

	// Branches resolve here, delay slot is already in fetch
	assign pcPlus4    = pcId + 32'd4;
	assign redirect   = !stall && (isJ || (isBeq && rsVal == rtVal));
	assign redirectPc = isJ ? {pcPlus4[31:28], instrId[25:0], 2'b00}
		: pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};

	//////////////////////////////////////////////////////////////
	// ID/EX register, bubble on stall
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			rsEx     <= '0;
			rtEx     <= '0;
			dstEx    <= '0;
			rsUseEx  <= useBranch;
			rtUseEx  <= useBranch;
			dstNewEx <= newNone;
			loadEx   <= 1'b0;
			storeEx  <= 1'b0;
		end else begin
			rsEx     <= rsId;
			rtEx     <= rtId;
			dstEx    <= dst;
			rsUseEx  <= rsUseId;
			rtUseEx  <= rtUseId;
			dstNewEx <= dstNew;
			loadEx   <= isLoad;
			storeEx  <= isStore;
		end
	end

	always_ff @(posedge clk) begin
		opEx     <= op;
		useImmEx <= useImm;
		rsValEx  <= rsVal;
		rtValEx  <= rtVal;
		immEx    <= immExt;
		pcEx     <= pcId;
	end

	noZeroWrite: assert property (@(posedge clk) disable iff (rst) wbEn |-> wbReg != '0)
		else $error("writeback enabled for register zero");

endmodule

// File: rtl/executeStage.sv
module executeStage import cpuPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  regAddr   rsEx,
	input  regAddr   rtEx,
	input  regAddr   dstEx,
	input  stageTime rsUseEx,
	input  stageTime rtUseEx,
	input  stageTime dstNewEx,
	input  aluOp     opEx,
	input  logic     useImmEx,
	input  logic     loadEx,
	input  logic     storeEx,
	input  dataWord  rsValEx,
	input  dataWord  rtValEx,
	input  dataWord  immEx,
	input  dataWord  pcEx,
	input  bypassSel aluIn0Sel,
	input  bypassSel aluIn1Sel,
	input  dataWord  memFwdData,
	input  dataWord  wbData,
	output regAddr   rsMem,
	output regAddr   rtMem,
	output regAddr   dstMem,
	output stageTime rtUseMem,
	output stageTime dstNewMem,
	output logic     loadMem,
	output logic     storeMem,
	output dataWord  aluOutMem,
	output dataWord  storeDataMem,
	output dataWord  pcMem
);

	dataWord aluIn0, rtFwd, aluIn1, aluOut;

	assign aluIn0 = (aluIn0Sel == bypMem) ? memFwdData : (aluIn0Sel == bypWb) ? wbData : rsValEx;
	assign rtFwd  = (aluIn1Sel == bypMem) ? memFwdData : (aluIn1Sel == bypWb) ? wbData : rtValEx;
	assign aluIn1 = useImmEx ? immEx : rtFwd;

	always_comb begin
		case (opEx)
			aluSub:  aluOut = aluIn0 - aluIn1;
			aluAnd:  aluOut = aluIn0 & aluIn1;
			aluOr:   aluOut = aluIn0 | aluIn1;
			aluSlt:  aluOut = {31'd0, $signed(aluIn0) < $signed(aluIn1)};
			aluLui:  aluOut = {aluIn1[15:0], 16'h0};
			default: aluOut = aluIn0 + aluIn1;
		endcase
	end

	//////////////////////////////////////////////////////////////
	// EX/Mem register
	always_ff @(posedge clk) begin
		if (rst) begin
			rsMem     <= '0;
			rtMem     <= '0;
			dstMem    <= '0;
			rtUseMem  <= useBranch;
			dstNewMem <= newNone;
			loadMem   <= 1'b0;
			storeMem  <= 1'b0;
		end else begin
			rsMem     <= rsEx;
			rtMem     <= rtEx;
			dstMem    <= dstEx;
			rtUseMem  <= rtUseEx;
			dstNewMem <= (dstNewEx == newNone) ? newNone : dstNewEx - 2'd1;
			loadMem   <= loadEx;
			storeMem  <= storeEx;
		end
	end

	always_ff @(posedge clk) begin
		aluOutMem    <= aluOut;
		storeDataMem <= rtFwd;
		pcMem        <= pcEx;
	end

	// Decode-only sources never need an execute bypass
	bypassOnlyForUsedRs: assert property (@(posedge clk) disable iff (rst)
		(aluIn0Sel != bypRf) |-> (rsUseEx != useBranch))
		else $error("execute bypass on a source consumed in decode");

endmodule

// File: rtl/memoryStage.sv
module memoryStage import cpuPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  regAddr  rsMem,
	input  regAddr  dstMem,
	input  logic    loadMem,
	input  logic    storeMem,
	input  dataWord aluOutMem,
	input  dataWord storeDataMem,
	input  dataWord pcMem,
	input  logic    storeSel,
	output dataWord memFwdData,
	output regAddr  wbReg,
	output dataWord wbData,
	output logic    wbEn,
	output dataWord wbPc,
	output logic    storeValid,
	output dataWord storeAddr,
	output dataWord storeData
);

	dataWord storeWord;
	dataWord loadWord;
	dataWord dmem [dmemDepth];

	// Load result one ahead lands in WB just in time
	assign storeWord = storeSel ? wbData : storeDataMem;
	assign loadWord  = dmem[aluOutMem[dmemAddrBits+1:2]];

	always_ff @(posedge clk) begin
		if (storeMem) begin
			dmem[aluOutMem[dmemAddrBits+1:2]] <= storeWord;
		end
	end

	assign memFwdData = aluOutMem;
	assign storeValid = storeMem;
	assign storeAddr  = aluOutMem;
	assign storeData  = storeWord;

	//////////////////////////////////////////////////////////////
	// Mem/WB register
	always_ff @(posedge clk) begin
		if (rst) begin
			wbEn  <= 1'b0;
			wbReg <= '0;
		end else begin
			wbEn  <= (dstMem != '0);
			wbReg <= dstMem;
		end
	end

	always_ff @(posedge clk) begin
		wbData <= loadMem ? loadWord : aluOutMem;
		wbPc   <= pcMem;
	end

	wordAligned: assert property (@(posedge clk) disable iff (rst)
		(loadMem || storeMem) |-> (aluOutMem[1:0] == 2'b00))
		else $error("unaligned data access, base register r%0d", rsMem);

endmodule

// File: rtl/hazardUnit.sv
module hazardUnit import cpuPkg::*; (
	input  regAddr   rsId,
	input  regAddr   rtId,
	input  stageTime rsUseId,
	input  stageTime rtUseId,
	input  regAddr   rsEx,
	input  regAddr   rtEx,
	input  stageTime rsUseEx,
	input  stageTime rtUseEx,
	input  regAddr   dstEx,
	input  stageTime dstNewEx,
	input  regAddr   rtMem,
	input  stageTime rtUseMem,
	input  regAddr   dstMem,
	input  stageTime dstNewMem,
	input  regAddr   wbReg,
	input  logic     wbEn,
	output logic     stall,
	output bypassSel rsSelId,
	output bypassSel rtSelId,
	output bypassSel aluIn0Sel,
	output bypassSel aluIn1Sel,
	output logic     storeSel
);

	// Value is needed before the producer can deliver it
	function automatic logic mustWait(regAddr src, stageTime useTime);
		logic waitEx, waitMem;
		waitEx  = (src == dstEx) && (useTime < dstNewEx);
		waitMem = (src == dstMem) && (useTime < dstNewMem);
		return (src != '0) && (waitEx || waitMem);
	endfunction

	// Youngest match wins, an unready Mem match leaves the stale value
	function automatic bypassSel pickSource(regAddr src);
		if (src == '0) begin
			return bypRf;
		end
		if (src == dstMem) begin
			return (dstNewMem == newNone) ? bypMem : bypRf;
		end
		if (wbEn && src == wbReg) begin
			return bypWb;
		end
		return bypRf;
	endfunction

	assign stall     = mustWait(rsId, rsUseId) || mustWait(rtId, rtUseId);
	assign rsSelId   = pickSource(rsId);
	assign rtSelId   = pickSource(rtId);
	assign aluIn0Sel = (rsUseEx != useBranch) ? pickSource(rsEx) : bypRf;
	assign aluIn1Sel = (rtUseEx != useBranch) ? pickSource(rtEx) : bypRf;

	// Store data fixed up from a load that has just reached WB
	assign storeSel = (rtUseMem == useStoreData) && wbEn && (rtMem != '0) && (rtMem == wbReg);

	// Stall must have let a Mem producer finish before an ALU operand needs it
	always_comb begin
		assert (dstMem == '0 || dstNewMem == newNone
			|| !((rsUseEx == useAlu && rsEx == dstMem) || (rtUseEx == useAlu && rtEx == dstMem)))
			else $error("execute operand bypass from a Mem stage value that is not ready");
	end

endmodule

// File: rtl/cpuTop.sv
module cpuTop import cpuPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    progWe,
	input  dataWord progAddr,
	input  dataWord progData,
	output logic    commitValid,
	output dataWord commitPc,
	output regAddr  commitReg,
	output dataWord commitData,
	output logic    storeValid,
	output dataWord storeAddr,
	output dataWord storeData
);

	logic     stall, redirect, useImmEx, loadEx, storeEx, loadMem, storeMem, storeSel, wbEn;
	dataWord  redirectPc, instrId, pcId, rsValEx, rtValEx, immEx, pcEx;
	dataWord  aluOutMem, storeDataMem, pcMem, memFwdData, wbData, wbPc;
	regAddr   rsId, rtId, rsEx, rtEx, dstEx, rsMem, rtMem, dstMem, wbReg;
	stageTime rsUseId, rtUseId, rsUseEx, rtUseEx, dstNewEx, rtUseMem, dstNewMem;
	bypassSel rsSelId, rtSelId, aluIn0Sel, aluIn1Sel;
	aluOp     opEx;

	//////////////////////////////////////////////////////////////
	fetchStage fetch (.clk, .rst, .progWe, .progAddr, .progData, .stall,
		.redirect, .redirectPc, .instrId, .pcId);

	decodeStage decode (.clk, .rst, .stall, .instrId, .pcId, .rsSelId, .rtSelId,
		.memFwdData, .wbReg, .wbData, .wbEn, .redirect, .redirectPc,
		.rsId, .rtId, .rsUseId, .rtUseId, .rsEx, .rtEx, .dstEx, .rsUseEx, .rtUseEx,
		.dstNewEx, .opEx, .useImmEx, .loadEx, .storeEx, .rsValEx, .rtValEx, .immEx, .pcEx);

	executeStage execute (.clk, .rst, .rsEx, .rtEx, .dstEx, .rsUseEx, .rtUseEx,
		.dstNewEx, .opEx, .useImmEx, .loadEx, .storeEx, .rsValEx, .rtValEx, .immEx,
		.pcEx, .aluIn0Sel, .aluIn1Sel, .memFwdData, .wbData, .rsMem, .rtMem, .dstMem,
		.rtUseMem, .dstNewMem, .loadMem, .storeMem, .aluOutMem, .storeDataMem, .pcMem);

	memoryStage memory (.clk, .rst, .rsMem, .dstMem, .loadMem, .storeMem,
		.aluOutMem, .storeDataMem, .pcMem, .storeSel, .memFwdData, .wbReg, .wbData,
		.wbEn, .wbPc, .storeValid, .storeAddr, .storeData);

	hazardUnit hazard (.rsId, .rtId, .rsUseId, .rtUseId, .rsEx, .rtEx, .rsUseEx,
		.rtUseEx, .dstEx, .dstNewEx, .rtMem, .rtUseMem, .dstMem, .dstNewMem,
		.wbReg, .wbEn, .stall, .rsSelId, .rtSelId, .aluIn0Sel, .aluIn1Sel, .storeSel);

	// Commit trace straight from Mem/WB
	assign commitValid = wbEn;
	assign commitPc    = wbPc;
	assign commitReg   = wbReg;
	assign commitData  = wbData;

endmodule

// File: include/testProgram.svh
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

localparam int progLen = 28;

// Word at byte address 4*i
localparam logic [31:0] progTable [progLen] = '{
	32'h24010005, 32'h24220003, 32'h00221821, 32'h00612023,
	32'h00642824, 32'h00A13025, 32'h0023382A, 32'hAC070004,
	32'h8C080004, 32'h25090001, 32'h3C0A1234, 32'h354A5678,
	32'h10210002, 32'h240B0007, 32'h240C0063, 32'h10220005,
	32'h240C0001, 32'h08000014, 32'h240D0002, 32'h240D0063,
	32'h8C0E0004, 32'h11C70002, 32'h240F0003, 32'h240F0063,
	32'h24000009, 32'h012B8021, 32'h0800001A, 32'h00000000
};

localparam int commitLen = 17;

// PC of each committing instruction
localparam logic [31:0] expCommitPc [commitLen] = '{
	32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14, 32'h18, 32'h20, 32'h24,
	32'h28, 32'h2C, 32'h34, 32'h40, 32'h48, 32'h50, 32'h58, 32'h64
};

localparam logic [4:0] expCommitReg [commitLen] = '{
	5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9,
	5'd10, 5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16
};

localparam logic [31:0] expCommitData [commitLen] = '{
	32'd5, 32'd8, 32'd13, 32'd8, 32'd8, 32'd13, 32'd1, 32'd1, 32'd2,
	32'h12340000, 32'h12345678, 32'd7, 32'd1, 32'd2, 32'd1, 32'd3, 32'd9
};

localparam int storeLen = 1;

localparam logic [31:0] expStoreAddr [storeLen] = '{32'd4};
localparam logic [31:0] expStoreData [storeLen] = '{32'd1};

`endif

// File: test/cpuTb.sv
module cpuTb import cpuPkg::*; ();

	`include "testProgram.svh"

	// Cycles after reset release
	localparam int timeoutCycles = progLen * 3 + 50;
	localparam int resetCycles   = 8;
	localparam int drainCycles   = 10;

	logic    clk;
	logic    rst;
	logic    progWe;
	dataWord progAddr;
	dataWord progData;
	logic    commitValid;
	dataWord commitPc;
	regAddr  commitReg;
	dataWord commitData;
	logic    storeValid;
	dataWord storeAddr;
	dataWord storeData;

	int valueErrors = 0;
	int eventErrors = 0;
	int commitIdx   = 0;
	int storeIdx    = 0;
	int cycleCount  = 0;

	cpuTop UUT (
		.clk,
		.rst,
		.progWe,
		.progAddr,
		.progData,
		.commitValid,
		.commitPc,
		.commitReg,
		.commitData,
		.storeValid,
		.storeAddr,
		.storeData
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			cycleCount <= 0;
		end else begin
			cycleCount <= cycleCount + 1;
		end
	end

	//////////////////////////////////////////////////////////////
	// Result checks
	task automatic checkCommit(input dataWord gotPc, input regAddr gotReg,
		input dataWord gotData, input dataWord expPc, input regAddr expReg,
		input dataWord expData);
		if (gotPc !== expPc || gotReg !== expReg || gotData !== expData) begin
			valueErrors++;
			$display("CHECK FAILED at %0t: pc %h wrote r%0d = %h, expected pc %h r%0d = %h",
				$time, gotPc, gotReg, gotData, expPc, expReg, expData);
		end
	endtask

	task automatic checkStore(input dataWord gotAddr, input dataWord gotData,
		input dataWord expAddr, input dataWord expData);
		if (gotAddr !== expAddr || gotData !== expData) begin
			valueErrors++;
			$display("CHECK FAILED at %0t: store to %h with data %h, expected %h to %h",
				$time, gotAddr, gotData, expData, expAddr);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Trace monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			if (commitValid === 1'b1 || storeValid === 1'b1) begin
				eventErrors++;
				$display("A commit or store strobe appeared during reset at time %0t", $time);
			end
		end else begin
			if (commitValid !== 1'b0 && commitValid !== 1'b1) begin
				eventErrors++;
				$display("The commit strobe is unknown at time %0t", $time);
			end
			if (storeValid !== 1'b0 && storeValid !== 1'b1) begin
				eventErrors++;
				$display("The store strobe is unknown at time %0t", $time);
			end
			if (commitValid === 1'b1) begin
				if (commitIdx < commitLen) begin
					checkCommit(commitPc, commitReg, commitData, expCommitPc[commitIdx],
						expCommitReg[commitIdx], expCommitData[commitIdx]);
					commitIdx++;
				end else begin
					eventErrors++;
					$display("An extra commit of r%0d from pc %h appeared at time %0t",
						commitReg, commitPc, $time);
				end
			end
			if (storeValid === 1'b1) begin
				if (storeIdx < storeLen) begin
					checkStore(storeAddr, storeData, expStoreAddr[storeIdx], expStoreData[storeIdx]);
					storeIdx++;
				end else begin
					eventErrors++;
					$display("An extra store to %h appeared at time %0t", storeAddr, $time);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Program load inside reset, then run
	initial begin
		int idx;
		rst      = 1'b1;
		progWe   = 1'b0;
		progAddr = '0;
		progData = '0;
		for (idx = 0; idx < progLen; idx++) begin
			@(posedge clk);
			#2;
			progWe   = 1'b1;
			progAddr = dataWord'(idx * 4);
			progData = progTable[idx];
		end
		@(posedge clk);
		#2;
		progWe = 1'b0;
		// Clean reset cycles with the program in place
		repeat (resetCycles) @(posedge clk);
		#2;
		rst = 1'b0;

		while (!(commitIdx == commitLen && storeIdx == storeLen) && cycleCount < timeoutCycles) begin
			@(posedge clk);
		end

		if (cycleCount >= timeoutCycles) begin
			eventErrors++;
			$display("Timeout after %0d cycles, saw %0d of %0d commits and %0d of %0d stores",
				cycleCount, commitIdx, commitLen, storeIdx, storeLen);
			$display("Errors: %0d value mismatches, %0d event errors", valueErrors, eventErrors);
			$display(">>> FAIL");
		end else begin
			// Let the loop at the end run to catch stray events
			repeat (drainCycles) @(posedge clk);
			$display("Errors: %0d value mismatches, %0d event errors", valueErrors, eventErrors);
			if (valueErrors == 0 && eventErrors == 0) begin
				$display(">>> PASS");
			end else begin
				$display(">>> FAIL");
			end
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+include
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/hazardUnit.sv
rtl/cpuTop.sv
test/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=cpuTbSim
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module cpuTb --Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
	echo "Verilator build failed"
	exit 1
fi

if ! "./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1; then
	cat "$LOG_FILE"
	echo "Simulation exited with an error status"
	exit 1
fi

cat "$LOG_FILE"

if grep -qx ">>> PASS" "$LOG_FILE"; then
	exit 0
fi

echo "Pass message not found in $LOG_FILE"
exit 1
